/* fpir_adder.sv */
`timescale 1ns/1ns

// Two-stage floating-point add and subtract
// Stage 1 orders and aligns, stage 2 adds, normalizes and rounds
module fpir_adder import fpir_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input fpir_req_t req,
	output logic out_valid,
	output fpir_res_t res
);

	// Effective operands, sub folded into b's sign
	fpir_t a_op;
	fpir_t b_op;
	logic a_ge_b;
	fpir_t big_op;
	fpir_t small_op;
	logic [exp_bits-1:0] exp_diff;
	logic [shift_bits-1:0] amount;
	logic [ext_bits-1:0] small_aligned;
	align_t s1_d;
	align_t s1_q;
	logic s1_valid;
	fpir_res_t res_d;

	// *************************************************************************
	// Stage 1: order and align
	// *************************************************************************

	always_comb begin
		a_op = req.a;
		b_op = req.b;
		b_op.sign = req.b.sign ^ (req.op == op_sub);
		// A zero operand adds nothing
		if (req.a.exp == '0) begin
			a_op.man = '0;
		end
		if (req.b.exp == '0) begin
			b_op.man = '0;
		end
	end

	// Magnitude compare, exponent first then significand
	assign a_ge_b = {a_op.exp, a_op.man} >= {b_op.exp, b_op.man};
	assign big_op = a_ge_b ? a_op : b_op;
	assign small_op = a_ge_b ? b_op : a_op;

	// Past ext_bits everything lands in sticky anyway
	assign exp_diff = big_op.exp - small_op.exp;
	assign amount = (exp_diff >= exp_bits'(ext_bits)) ? shift_bits'(ext_bits)
		: exp_diff[shift_bits-1:0];

	fpir_align_shifter align_inst (
		.man({small_op.man, {grd_bits{1'b0}}}),
		.amount(amount),
		.aligned(small_aligned)
	);

	always_comb begin
		s1_d.sign = big_op.sign;
		s1_d.exp = big_op.exp;
		s1_d.big_man = {big_op.man, {grd_bits{1'b0}}};
		s1_d.small_man = small_aligned;
		s1_d.eff_sub = a_op.sign ^ b_op.sign;
		// Negative only when both effective signs are negative
		s1_d.zero_sign = a_op.sign & b_op.sign;
		s1_d.rmode = req.rmode;
	end

	// *************************************************************************
	// Pipeline registers
	// *************************************************************************

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_q <= s1_d;
		end
	end

	// Stage 2 combinational datapath
	fpir_normalizer norm_inst (
		.stage(s1_q),
		.res(res_d)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
			res <= '0;
		end else begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
			// Hold the last result between requests
			if (s1_valid) begin
				res <= res_d;
			end
		end
	end

endmodule

/* fpir_adder_assertions.sv */
`timescale 1ns/1ns

// Pipeline properties of fpir_adder, attached to the DUT by bind
module fpir_adder_assertions import fpir_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input fpir_res_t res
);

	// Valid output stays low while reset is held
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid went high during reset");

	// Fixed latency of two, one result per accepted request
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	// Zero results never carry a nonzero exponent
	a_zero_exp: assert property (@(posedge clk) disable iff (!rst_n)
		res.zero |-> (res.result.exp == '0))
		else $error("zero flag set with a nonzero result exponent");

endmodule

bind fpir_adder fpir_adder_assertions assertions_inst (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.res(res)
);

/* fpir_align_shifter.sv */
`timescale 1ns/1ns

// Right shift of the smaller significand for alignment
// Bits shifted out end up in the aligned LSB as a sticky bit
module fpir_align_shifter import fpir_pkg::*; (
	input logic [ext_bits-1:0] man,
	input logic [shift_bits-1:0] amount,
	output logic [ext_bits-1:0] aligned
);

	// Significand with room underneath for the largest shift
	logic [align_wide_bits-1:0] widened;
	logic [align_wide_bits-1:0] moved;
	// Jam result, top bit is the carry and always stays low
	logic [ext_bits:0] jammed;

	assign widened = {man, {align_pad_bits{1'b0}}};

	fpir_barrel_shifter #(
		.data_w(align_wide_bits),
		.amt_w(shift_bits)
	) barrel_inst (
		.data(widened),
		.amount(amount),
		.shifted(moved)
	);

	// Remove the extension, OR its contents into the kept LSB
	fpir_round #(
		.in_w(align_wide_bits),
		.drop_w(align_pad_bits)
	) jam_inst (
		.value(moved),
		.mode(rm_jam),
		.rounded(jammed),
		.inexact()
	);

	assign aligned = jammed[ext_bits-1:0];

endmodule

/* fpir_barrel_shifter.sv */
`timescale 1ns/1ns

// Logical right shifter built from log2 stages
// Stage i moves the data by 2**i when amount bit i is set
module fpir_barrel_shifter #(
	parameter int data_w = 32,
	parameter int amt_w = 5
) (
	input logic [data_w-1:0] data,
	input logic [amt_w-1:0] amount,
	output logic [data_w-1:0] shifted
);

	// *************************************************************************
	// Shift network
	// *************************************************************************

	// Slice 0 is the raw input, slice amt_w is the final result
	logic [amt_w:0][data_w-1:0] stage;

	assign stage[0] = data;

	for (genvar i = 0; i < amt_w; i++) begin : g_stage
		// Zero fill from the top
		// A step of 2**i at or past data_w clears the slice entirely
		always_comb begin
			if (amount[i]) begin
				stage[i+1] = stage[i] >> (2 ** i);
			end else begin
				stage[i+1] = stage[i];
			end
		end
	end

	// Sum of the enabled steps equals amount
	// so amounts of data_w or more give zero
	assign shifted = stage[amt_w];

endmodule

/* fpir_normalizer.sv */
`timescale 1ns/1ns

// Stage 2 datapath: significand add, normalize, round, flags
module fpir_normalizer import fpir_pkg::*; (
	input align_t stage,
	output fpir_res_t res
);

	// Raw sum with carry bit
	logic [ext_bits:0] sum;
	logic sum_zero;
	// Leading zeros of the sum below the carry, ext_bits when all clear
	logic [shift_bits-1:0] lz;
	logic [ext_bits-1:0] norm;
	// Two extra bits for carry and borrow headroom
	logic [exp_bits+1:0] exp_n;
	logic [exp_bits+1:0] exp_r;
	logic under;
	logic [man_bits:0] rounded;
	logic [man_bits-1:0] man_r;

	// Big operand never smaller than the aligned one, no borrow out
	assign sum = stage.eff_sub ? {1'b0, stage.big_man} - {1'b0, stage.small_man}
		: {1'b0, stage.big_man} + {1'b0, stage.small_man};
	assign sum_zero = (sum == '0);

	// Leading zero count, highest set bit wins
	always_comb begin
		lz = shift_bits'(ext_bits);
		for (int i = 0; i < ext_bits; i++) begin
			if (sum[i]) begin
				lz = shift_bits'(ext_bits - 1 - i);
			end
		end
	end

	always_comb begin
		under = 1'b0;
		if (sum[ext_bits]) begin
			// Carry out, one step right with the lost bit kept as sticky
			norm = {sum[ext_bits:2], sum[1] | sum[0]};
			exp_n = {2'b00, stage.exp} + 1'b1;
		end else begin
			norm = sum[ext_bits-1:0] << lz;
			exp_n = {2'b00, stage.exp} - (exp_bits + 2)'(lz);
			// No denormals, anything at exponent zero or below flushes
			under = ({2'b00, stage.exp} <= (exp_bits + 2)'(lz));
		end
	end

	fpir_round #(
		.in_w(ext_bits),
		.drop_w(grd_bits)
	) round_inst (
		.value(norm),
		.mode(stage.rmode),
		.rounded(rounded),
		.inexact()
	);

	// Rounding carry gives 1.000..0, renormalize by one
	assign exp_r = exp_n + (exp_bits + 2)'(rounded[man_bits]);
	assign man_r = rounded[man_bits] ? rounded[man_bits:1] : rounded[man_bits-1:0];

	always_comb begin
		res = '0;
		if (sum_zero) begin
			res.zero = 1'b1;
			res.result.sign = stage.zero_sign;
		end else if (under) begin
			res.zero = 1'b1;
			res.result.sign = stage.sign;
		end else if (exp_r >= (exp_bits + 2)'(exp_max)) begin
			// Saturate to the largest finite value
			res.overflow = 1'b1;
			res.result.sign = stage.sign;
			res.result.exp = exp_bits'(exp_max - 1);
			res.result.man = '1;
		end else begin
			res.result.sign = stage.sign;
			res.result.exp = exp_r[exp_bits-1:0];
			res.result.man = man_r;
		end
	end

endmodule

/* fpir_pkg.sv */
package fpir_pkg;

	// *************************************************************************
	// Number format
	// *************************************************************************

	// Stored exponent width
	localparam int exp_bits = 8;
	// Significand width, leading one is explicit
	localparam int man_bits = 24;
	// Bias of the stored exponent
	localparam int exp_bias = 127;
	// Guard, round and sticky positions carried below the significand
	localparam int grd_bits = 3;
	// Alignment amount width
	localparam int shift_bits = 5;
	// Largest exponent code, results reaching it overflow
	localparam int exp_max = 255;

	// Significand plus the guard positions
	localparam int ext_bits = man_bits + grd_bits;
	// Zero bits placed under the significand so a full shift loses nothing
	localparam int align_pad_bits = (1 << shift_bits) - 1;
	// Width seen by the alignment barrel shifter
	localparam int align_wide_bits = ext_bits + align_pad_bits;

	// *************************************************************************
	// Types
	// *************************************************************************

	// rm_jam is internal only, it folds all dropped bits into the kept LSB
	typedef enum logic [1:0] {
		rm_rne,
		rm_rtz,
		rm_jam
	} round_mode_e;

	typedef enum logic {
		op_add,
		op_sub
	} fp_op_e;

	// One number, exp of zero means the value zero
	typedef struct packed {
		logic sign;
		logic [exp_bits-1:0] exp;
		logic [man_bits-1:0] man;
	} fpir_t;

	typedef struct packed {
		fpir_t a;
		fpir_t b;
		fp_op_e op;
		round_mode_e rmode;
	} fpir_req_t;

	typedef struct packed {
		fpir_t result;
		logic overflow;
		logic zero;
	} fpir_res_t;

	// Stage 1 to stage 2 register contents
	typedef struct packed {
		logic sign;                      // sign of the larger magnitude
		logic [exp_bits-1:0] exp;        // exponent of the larger magnitude
		logic [ext_bits-1:0] big_man;
		logic [ext_bits-1:0] small_man;  // already aligned, sticky in LSB
		logic eff_sub;
		logic zero_sign;                 // result sign if the sum cancels to zero
		round_mode_e rmode;
	} align_t;

endpackage

/* fpir_round.sv */
`timescale 1ns/1ns

// Drops the low drop_w bits of value under the selected mode
// Result keeps a carry bit on top of the kept field
module fpir_round import fpir_pkg::*; #(
	parameter int in_w = 27,
	parameter int drop_w = 3
) (
	input logic [in_w-1:0] value,
	input round_mode_e mode,
	output logic [in_w-drop_w:0] rounded,
	output logic inexact
);

	// *************************************************************************
	// Split
	// *************************************************************************

	// Kept field and the bits that go away
	logic [in_w-drop_w-1:0] kept;
	logic [drop_w-1:0] lost;
	// Lost bits with the guard shifted out
	logic [drop_w-1:0] below;
	logic guard;
	logic sticky;

	assign kept = value[in_w-1:drop_w];
	assign lost = value[drop_w-1:0];

	// Guard is the first dropped bit
	assign guard = lost[drop_w-1];
	// Everything under the guard collapses into sticky
	assign below = lost << 1;
	assign sticky = |below;

	assign inexact = guard | sticky;

	// *************************************************************************
	// Mode select
	// *************************************************************************

	always_comb begin
		// Truncation unless a mode below changes it
		rounded = {1'b0, kept};
		case (mode)
			rm_rne: begin
				// Above half, or exactly half with an odd kept field
				if (guard && (sticky || kept[0])) begin
					rounded = {1'b0, kept} + 1'b1;
				end
			end
			rm_jam: begin
				// Never carries, only marks that something was lost
				rounded[0] = kept[0] | guard | sticky;
			end
			rm_rtz: begin
				rounded = {1'b0, kept};
			end
			default: begin
				rounded = {1'b0, kept};
			end
		endcase
	end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpir_adder -f tb.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" ||
{ echo "FAIL"; exit 1; }

/* tb.f */
fpir_pkg.sv
fpir_barrel_shifter.sv
fpir_round.sv
fpir_align_shifter.sv
fpir_normalizer.sv
fpir_adder.sv
fpir_adder_assertions.sv
tb_fpir_checker.sv
tb_fpir_adder.sv

/* tb_fpir_adder.sv */
`timescale 1ns/1ns

// Testbench top for the two-stage floating-point adder
module tb_fpir_adder import fpir_pkg::*; ();

	localparam int num_random = 200;

	typedef struct packed {
		fpir_req_t req;
		fpir_res_t res;
	} vector_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	fpir_req_t req;
	logic out_valid;
	fpir_res_t res;
	logic ref_valid;
	fpir_res_t ref_res;
	int value_errors;
	int protocol_errors;
	int cycles = 0;
	int cycle_limit = 1000;
	logic [31:0] seed;
	// Directed operands with hand-worked results
	vector_t table_q[$];

	fpir_adder fpir_adder_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.req(req),
		.out_valid(out_valid),
		.res(res)
	);

	tb_fpir_checker checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.req(req),
		.ref_valid(ref_valid),
		.ref_res(ref_res),
		.out_valid(out_valid),
		.res(res),
		.value_errors(value_errors),
		.protocol_errors(protocol_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ************************************************************************
	// Stimulus helpers
	// ************************************************************************

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Numbers are written as sign_exp_man
	task automatic add_vector(input fpir_t a, input fpir_t b, input fp_op_e op,
		input round_mode_e rm, input fpir_t result, input logic ov, input logic zero);
		vector_t v;
		v.req = {a, b, op, rm};
		v.res = {result, ov, zero};
		table_q.push_back(v);
	endtask

	// Exponent 100 to 154 with the leading one set
	task automatic random_operand(output fpir_t x);
		seed = lcg_next(seed);
		x.sign = seed[31];
		x.exp = exp_bits'(100 + (seed[30:16] % 55));
		seed = lcg_next(seed);
		x.man = {1'b1, seed[30:8]};
	endtask

	task automatic random_req(output fpir_req_t r);
		fpir_t a;
		fpir_t b;
		random_operand(a);
		random_operand(b);
		seed = lcg_next(seed);
		r.a = a;
		r.b = b;
		r.op = seed[29] ? op_sub : op_add;
		r.rmode = seed[28] ? rm_rtz : rm_rne;
	endtask

	task automatic load_table();
		// Equal exponents with carry out and ties to even
		add_vector(33'h0_7f_800000, 33'h0_7f_800000, op_add, rm_rne, 33'h0_80_800000, 0, 0);
		add_vector(33'h0_7f_800000, 33'h0_7f_c00000, op_add, rm_rne, 33'h0_80_a00000, 0, 0);
		add_vector(33'h0_7f_800001, 33'h0_7f_800000, op_add, rm_rne, 33'h0_80_800000, 0, 0);
		add_vector(33'h0_7f_800001, 33'h0_7f_800000, op_add, rm_rtz, 33'h0_80_800000, 0, 0);
		add_vector(33'h0_7f_800003, 33'h0_7f_800000, op_add, rm_rne, 33'h0_80_800002, 0, 0);
		add_vector(33'h0_7f_800003, 33'h0_7f_800000, op_add, rm_rtz, 33'h0_80_800001, 0, 0);
		// Exponents two apart
		add_vector(33'h0_7f_800000, 33'h0_7d_800007, op_add, rm_rne, 33'h0_7f_a00002, 0, 0);
		add_vector(33'h0_7f_800000, 33'h0_7d_800007, op_add, rm_rtz, 33'h0_7f_a00001, 0, 0);
		add_vector(33'h0_7f_800000, 33'h0_7d_800002, op_add, rm_rne, 33'h0_7f_a00000, 0, 0);
		add_vector(33'h0_7f_800000, 33'h0_7d_800002, op_add, rm_rtz, 33'h0_7f_a00000, 0, 0);
		// Cancellation and exact zeros
		add_vector(33'h0_7f_800001, 33'h0_7f_800000, op_sub, rm_rne, 33'h0_68_800000, 0, 0);
		add_vector(33'h0_82_c00000, 33'h0_82_c00000, op_sub, rm_rne, 33'h0_00_000000, 0, 1);
		add_vector(33'h1_82_c00000, 33'h1_82_c00000, op_sub, rm_rtz, 33'h0_00_000000, 0, 1);
		add_vector(33'h1_00_000000, 33'h1_00_000000, op_add, rm_rne, 33'h1_00_000000, 0, 1);
		// Difference far past the significand where only sticky survives
		add_vector(33'h0_a0_800000, 33'h0_64_ffffff, op_add, rm_rne, 33'h0_a0_800000, 0, 0);
		add_vector(33'h0_a0_800000, 33'h0_64_ffffff, op_add, rm_rtz, 33'h0_a0_800000, 0, 0);
		add_vector(33'h0_a0_800000, 33'h0_64_ffffff, op_sub, rm_rne, 33'h0_a0_800000, 0, 0);
		add_vector(33'h0_a0_800000, 33'h0_64_ffffff, op_sub, rm_rtz, 33'h0_9f_ffffff, 0, 0);
		// Overflow saturates
		add_vector(33'h0_fe_ffffff, 33'h0_fe_ffffff, op_add, rm_rne, 33'h0_fe_ffffff, 1, 0);
		add_vector(33'h1_fe_c00000, 33'h1_fe_c00000, op_add, rm_rtz, 33'h1_fe_ffffff, 1, 0);
		// Zero operands pass the other one through
		add_vector(33'h0_00_000000, 33'h1_8c_abcdef, op_add, rm_rne, 33'h1_8c_abcdef, 0, 0);
		add_vector(33'h0_00_7fffff, 33'h0_81_876543, op_add, rm_rtz, 33'h0_81_876543, 0, 0);
		add_vector(33'h0_85_912345, 33'h1_00_000000, op_sub, rm_rne, 33'h0_85_912345, 0, 0);
		// Sign follows the larger magnitude
		add_vector(33'h1_80_800000, 33'h0_7f_800000, op_add, rm_rne, 33'h1_7f_800000, 0, 0);
		add_vector(33'h0_7f_800000, 33'h0_80_800000, op_sub, rm_rne, 33'h1_7f_800000, 0, 0);
	endtask

	// ************************************************************************
	// Run control
	// ************************************************************************

	// Cycles counted from reset release
	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles >= cycle_limit) begin
				$display("Timeout: results still missing after %0d cycles", cycle_limit);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial begin
		fpir_req_t r;
		rst_n = 1'b0;
		in_valid = 1'b0;
		req = '0;
		ref_valid = 1'b0;
		ref_res = '0;
		seed = 32'd15;
		load_table();
		// Every request plus drain margin
		cycle_limit = table_q.size() + num_random + 50;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		// Directed entries back to back
		foreach (table_q[i]) begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			req = table_q[i].req;
			ref_valid = 1'b1;
			ref_res = table_q[i].res;
		end
		for (int n = 0; n < num_random; n++) begin
			random_req(r);
			@(posedge clk);
			#1;
			in_valid = 1'b0 | 1'b1;
			req = r;
			ref_valid = 1'b0;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		// Last result lands two cycles after its request is taken
		repeat (2) @(posedge clk);
		#1;
		checker_inst.check_drained();
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb_fpir_checker.sv */
`timescale 1ns/1ns

// Scoreboard for fpir_adder
// Expected results come from exact integer sums of the operands
module tb_fpir_checker import fpir_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input fpir_req_t req,
	input logic ref_valid,
	input fpir_res_t ref_res,
	input logic out_valid,
	input fpir_res_t res,
	output int value_errors,
	output int protocol_errors
);

	// Room for a significand moved up by the largest exponent plus a carry bit
	localparam int wide_w = 288;

	typedef struct packed {
		logic has_ref;
		fpir_res_t ref_res;
		fpir_res_t model_res;
	} entry_t;

	// Requests in flight with the oldest first
	entry_t flight_q[$];

	// ************************************************************************
	// Reference model
	// ************************************************************************

	// Top significand bit lands at bit exp + man_bits - 1
	function automatic logic [wide_w-1:0] scaled(input fpir_t x);
		if (x.exp == '0) begin
			return '0;
		end
		return {{(wide_w-man_bits){1'b0}}, x.man} << x.exp;
	endfunction

	function automatic fpir_res_t model_add(input fpir_req_t r);
		fpir_res_t out;
		logic [wide_w-1:0] mag_a;
		logic [wide_w-1:0] mag_b;
		logic [wide_w-1:0] sum;
		logic [wide_w-1:0] half;
		logic [wide_w-1:0] rem;
		logic [man_bits:0] kept;
		logic sign_a;
		logic sign_b;
		logic sign_r;
		logic up;
		logic under;
		int msb;
		int drop;
		int exp_r;
		out = '0;
		up = 1'b0;
		msb = 0;
		sign_a = r.a.sign;
		// Subtraction is addition with b negated
		sign_b = r.b.sign ^ (r.op == op_sub);
		mag_a = scaled(r.a);
		mag_b = scaled(r.b);
		if (sign_a == sign_b) begin
			sum = mag_a + mag_b;
			sign_r = sign_a;
		end else if (mag_a >= mag_b) begin
			sum = mag_a - mag_b;
			sign_r = sign_a;
		end else begin
			sum = mag_b - mag_a;
			sign_r = sign_b;
		end
		// Exact zero is negative only for two negative terms
		if (sum == '0) begin
			out.zero = 1'b1;
			out.result.sign = sign_a & sign_b;
			return out;
		end
		for (int i = 0; i < wide_w; i++) begin
			if (sum[i]) begin
				msb = i;
			end
		end
		// Top bit at exp + man_bits - 1 gives the biased exponent directly
		exp_r = msb - (man_bits - 1);
		// Flush decided before rounding
		under = (exp_r <= 0);
		if (exp_r > 0) begin
			drop = exp_r;
			kept = (man_bits + 1)'(sum >> drop);
			half = '0;
			half[drop-1] = 1'b1;
			rem = sum & ((half << 1) - 1'b1);
			// Nearest even with ties to the even significand
			up = (r.rmode == rm_rne) && ((rem > half) || ((rem == half) && kept[0]));
		end else begin
			kept = (man_bits + 1)'(sum << (1 - exp_r));
		end
		kept = kept + (man_bits + 1)'(up);
		if (kept[man_bits]) begin
			kept = kept >> 1;
			exp_r++;
		end
		if (under) begin
			out.zero = 1'b1;
			out.result.sign = sign_r;
		end else if (exp_r >= exp_max) begin
			out.overflow = 1'b1;
			out.result = {sign_r, exp_bits'(exp_max - 1), {man_bits{1'b1}}};
		end else begin
			out.result = {sign_r, exp_bits'(exp_r), kept[man_bits-1:0]};
		end
		return out;
	endfunction

	// ************************************************************************
	// Comparison
	// ************************************************************************

	task automatic compare(input fpir_res_t want, input string source);
		if (res.result !== want.result) begin
			$display("ERROR res.result is %h, %s expects %h", res.result, source, want.result);
			value_errors++;
		end
		if (res.overflow !== want.overflow) begin
			$display("ERROR res.overflow is %h, %s expects %h", res.overflow, source,
				want.overflow);
			value_errors++;
		end
		if (res.zero !== want.zero) begin
			$display("ERROR res.zero is %h, %s expects %h", res.zero, source, want.zero);
			value_errors++;
		end
	endtask

	task automatic check_drained();
		if (flight_q.size() != 0) begin
			$display("%0d requests never produced a result", flight_q.size());
			protocol_errors++;
		end
	endtask

	initial begin
		value_errors = 0;
		protocol_errors = 0;
	end

	// Sample on the falling edge where DUT outputs and driven inputs have settled
	always @(negedge clk) begin
		entry_t e;
		if (rst_n && out_valid) begin
			if (flight_q.size() == 0) begin
				$display("A result appeared with no request waiting for it");
				protocol_errors++;
			end else begin
				e = flight_q.pop_front();
				compare(e.model_res, "model");
				if (e.has_ref) begin
					compare(e.ref_res, "table");
				end
			end
		end
		// Request taken on the coming rising edge
		if (rst_n && in_valid) begin
			e.has_ref = ref_valid;
			e.ref_res = ref_res;
			e.model_res = model_add(req);
			flight_q.push_back(e);
		end
	end

endmodule
